/* rtl/gba_loader_pkg.sv */
package gba_loader_pkg;

	// ========================================
	// Download stream types
	// ========================================

	typedef enum logic [1:0] {
		dl_none, // No download in progress
		dl_bios, // Index zero
		dl_cart, // Any index other than zero or all ones
		dl_code  // Index all ones, cheat list
	} dl_kind_e;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [26:0] addr;  // Byte address
		logic [15:0] dout;
		logic        wr;
	} ioctl_bus_t;

	typedef struct packed {
		dl_kind_e    kind;
		logic        active;
		logic        start;  // One cycle at download rise
		logic        finish; // One cycle at download fall
		logic        wr;
		logic [26:0] addr;
		logic [15:0] dout;   // Carries the index in cycles without a write
	} dl_event_t;

	// ========================================
	// Results
	// ========================================

	typedef struct packed {
		logic [11:0] addr; // Word address
		logic [31:0] data;
	} bios_write_t;

	// Same field order as the cheat engine expects
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic sram_off;
		logic memory_remap;
		logic gpio;
		logic tilt;
		logic solar;
	} quirk_flags_t;

	typedef struct packed {
		logic         loaded;
		logic [1:0]   cart_type;
		logic         flash_1m;
		logic [26:0]  last_addr;
		quirk_flags_t quirks;
	} cart_info_t;

	typedef struct packed {
		logic [95:0]  title; // 12 ASCII bytes, left justified
		quirk_flags_t flags;
	} quirk_entry_t;

	// ========================================
	// Constants
	// ========================================

	localparam logic [22:0] TITLE_ROW        = 23'hA; // Header bytes 0xA0..0xAF
	localparam logic [3:0]  TITLE_CMP_OFFSET = 4'd12;
	localparam logic [71:0] FLASH_MARKER     = "FLASH1M_V";
	localparam logic [7:0]  CODE_INDEX       = 8'hFF;
	localparam int          QUIRK_COUNT      = 8;
	localparam int          BIOS_ADDR_LSB    = 2;

	// Flag order is sram_off, memory_remap, gpio, tilt, solar
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{"ROCKY BOXING",               5'b10000},
		'{"DBZ LGCYGOKU",               5'b10000},
		'{{"BOMBER MAN", 16'h0000},     5'b11000}, // Classic NES series
		'{{"SUPER MARIO", 8'h00},       5'b11000},
		'{"POKEMON EMER",               5'b00100}, // Cart RTC on GPIO
		'{{"BOKTAI", 48'h000000000000}, 5'b00101}, // Solar sensor
		'{{"YOSHI TOPSY", 8'h00},       5'b00010},
		'{"WARIOTWISTED",               5'b00100}  // Gyro on GPIO
	};

endpackage

/* rtl/download_decode.sv */
module download_decode
	import gba_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	output dl_event_t  dl_event
);

	dl_kind_e kind_next;

	// Kind stays valid through the finish cycle so scanners can match on it
	always_comb begin
		if (!(ioctl.download || dl_event.active))
			kind_next = dl_none;
		else if (ioctl.index == '0)
			kind_next = dl_bios;
		else if (ioctl.index == CODE_INDEX)
			kind_next = dl_code;
		else
			kind_next = dl_cart;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_event.kind   <= dl_none;
			dl_event.active <= 1'b0;
			dl_event.start  <= 1'b0;
			dl_event.finish <= 1'b0;
			dl_event.wr     <= 1'b0;
		end else begin
			dl_event.kind   <= kind_next;
			dl_event.active <= ioctl.download;                       // Also the previous level
			dl_event.start  <= ioctl.download & ~dl_event.active;
			dl_event.finish <= ~ioctl.download & dl_event.active;
			dl_event.wr     <= ioctl.download & ioctl.wr;            // Stray strobes dropped
		end
		dl_event.addr <= ioctl.addr;
		// Index rides the data lane while no write is on the bus
		dl_event.dout <= ioctl.wr ? ioctl.dout : {8'h00, ioctl.index};
	end

	// The host must not write in the rising cycle
	start_no_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(dl_event.start && dl_event.wr));

endmodule

/* rtl/cart_header_scan.sv */
module cart_header_scan
	import gba_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  dl_event_t  dl_event,
	output cart_info_t cart
);

	logic         cart_start;
	logic         cart_finish;
	logic         cart_wr;
	logic [15:0]  dout_swap;    // Bytes in memory order
	logic [63:0]  history;      // Last eight bytes of the ROM
	logic         flash_hit;
	logic         title_row;
	logic         title_cmp;
	logic [95:0]  title;
	logic [26:0]  last_wr_addr;
	quirk_flags_t quirk_hits;

	assign cart_start  = dl_event.start  && dl_event.kind == dl_cart;
	assign cart_finish = dl_event.finish && dl_event.kind == dl_cart;
	assign cart_wr     = dl_event.wr     && dl_event.kind == dl_cart;

	assign dout_swap = {dl_event.dout[7:0], dl_event.dout[15:8]};

	// ========================================
	// Flash marker search
	// ========================================

	// Marker may end on either byte of the incoming halfword
	always_comb begin
		flash_hit = 1'b0;
		if ({history, dl_event.dout[7:0]} == FLASH_MARKER)
			flash_hit = 1'b1;    // Even byte alignment
		if ({history[55:0], dout_swap} == FLASH_MARKER)
			flash_hit = 1'b1;    // Odd byte alignment
	end

	// ========================================
	// Title lookup
	// ========================================

	assign title_row = cart_wr && dl_event.addr[26:4] == TITLE_ROW;
	assign title_cmp = title_row && dl_event.addr[3:0] == TITLE_CMP_OFFSET;

	// Flags of all matching entries add up
	always_comb begin
		quirk_hits = '0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (title == QUIRK_TABLE[i].title)
				quirk_hits = quirk_hits | QUIRK_TABLE[i].flags;
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			history      <= {history[47:0], dout_swap};
			last_wr_addr <= dl_event.addr;
		end
		// First halfword lands in the top bits
		if (title_row && dl_event.addr[3:0] < TITLE_CMP_OFFSET)
			title[{4'd10 - dl_event.addr[3:0], 3'd0} +: 16] <= dout_swap;
	end

	// ========================================
	// Cart result
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart.loaded    <= 1'b0;
			cart.cart_type <= 2'b00;
			cart.flash_1m  <= 1'b0;
			cart.last_addr <= '0;
			cart.quirks    <= '0;
		end else begin
			if (cart_start) begin
				cart.loaded    <= 1'b1;
				cart.cart_type <= dl_event.dout[7:6]; // Index bits 7..6
				cart.flash_1m  <= 1'b0;
				cart.quirks    <= '0;
			end

			if (cart_wr && flash_hit)
				cart.flash_1m <= 1'b1;

			if (title_cmp)
				cart.quirks <= cart.quirks | quirk_hits;

			if (cart_finish)
				cart.last_addr <= last_wr_addr;
		end
	end

endmodule

/* rtl/bios_word_pack.sv */
module bios_word_pack
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_event_t   dl_event,
	input  logic        bios_homebrew,
	output logic        bios_wr,
	output bios_write_t bios_write
);

	logic bios_dl_wr;
	logic high_half;

	// Homebrew option keeps the built-in image untouched
	assign bios_dl_wr = dl_event.wr && dl_event.kind == dl_bios && !bios_homebrew;
	assign high_half  = dl_event.addr[1];

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_dl_wr & high_half; // Word complete
	end

	always_ff @(posedge clk_sys) begin
		if (bios_dl_wr) begin
			if (!high_half) begin
				bios_write.data[15:0] <= dl_event.dout;
			end else begin
				bios_write.data[31:16] <= dl_event.dout;
				bios_write.addr        <= dl_event.addr[BIOS_ADDR_LSB +: 12];
			end
		end
	end

	// Halfwords alternate, so two words back to back mean a broken stream
	bios_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr);

endmodule

/* rtl/cheat_code_assemble.sv */
module cheat_code_assemble
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_event_t   dl_event,
	output logic        cheat_clear,
	output logic        cheat_valid,
	output cheat_code_t cheat_code
);

	logic code_start;
	logic code_wr;

	assign code_start = dl_event.start && dl_event.kind == dl_code;
	assign code_wr    = dl_event.wr    && dl_event.kind == dl_code;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_clear <= code_start;                            // Old list dropped
			cheat_valid <= code_wr && dl_event.addr[3:0] == 4'd14; // Last halfword of a code
		end
	end

	// ========================================
	// Halfword steering, 16 bytes per code
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_event.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl_event.dout;
				4'd2:  cheat_code.flags[31:16]   <= dl_event.dout;
				4'd4:  cheat_code.address[15:0]  <= dl_event.dout;
				4'd6:  cheat_code.address[31:16] <= dl_event.dout;
				4'd8:  cheat_code.compare[15:0]  <= dl_event.dout;
				4'd10: cheat_code.compare[31:16] <= dl_event.dout;
				4'd12: cheat_code.replace[15:0]  <= dl_event.dout;
				4'd14: cheat_code.replace[31:16] <= dl_event.dout;
				default: ; // Odd offsets carry nothing
			endcase
		end
	end

	// A code never completes in the same cycle the list is wiped
	clear_valid_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cheat_clear && cheat_valid));

endmodule

/* rtl/gba_loader.sv */
module gba_loader
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	input  logic        bios_homebrew,

	// Firmware writes
	output logic        bios_wr,
	output bios_write_t bios_write,

	// Cheat list
	output logic        cheat_clear,
	output logic        cheat_valid,
	output cheat_code_t cheat_code,

	// Cart status levels
	output cart_info_t  cart
);

	dl_event_t dl_event;

	// ========================================
	// Stream input
	// ========================================

	download_decode u_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.dl_event (dl_event)
	);

	// ========================================
	// Scanners, all fed by the same stream
	// ========================================

	cart_header_scan u_cart (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_event (dl_event),
		.cart     (cart)
	);

	bios_word_pack u_bios (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_event      (dl_event),
		.bios_homebrew (bios_homebrew),
		.bios_wr       (bios_wr),
		.bios_write    (bios_write)
	);

	cheat_code_assemble u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_event    (dl_event),
		.cheat_clear (cheat_clear),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code)
	);

endmodule

/* dv/gba_loader_tb.sv */
module gba_loader_tb
	import gba_loader_pkg::*;
();

	localparam int WAIT_LIMIT = 32; // Cycles allowed for any strobe

	logic        clk_sys;
	logic        reset;
	ioctl_bus_t  ioctl;
	logic        bios_homebrew;
	logic        bios_wr;
	bios_write_t bios_write;
	logic        cheat_clear;
	logic        cheat_valid;
	cheat_code_t cheat_code;
	cart_info_t  cart;

	logic [31:0] lfsr_state;
	int          test_count;
	int          error_count;

	gba_loader uut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ioctl         (ioctl),
		.bios_homebrew (bios_homebrew),
		.bios_wr       (bios_wr),
		.bios_write    (bios_write),
		.cheat_clear   (cheat_clear),
		.cheat_valid   (cheat_valid),
		.cheat_code    (cheat_code),
		.cart          (cart)
	);

	always #4 clk_sys = ~clk_sys;

	// ========================================
	// Random filler
	// ========================================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic filler_halfword(output logic [15:0] half);
		half = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			half       = {half[14:0], lfsr_state[0]};
		end
		half = half | 16'h8080; // Both bytes above ASCII, so no marker can form
	endtask

	// ========================================
	// Loader bus driving
	// ========================================

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.wr       = 1'b0;
		step();
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		ioctl.wr       = 1'b0;
		step();
	endtask

	task automatic drive_write(input logic [26:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		step();
		ioctl.wr   = 1'b0;
	endtask

	task automatic fill_writes(input logic [26:0] addr, input int count);
		logic [15:0] half;
		logic [26:0] a;
		a = addr;
		for (int i = 0; i < count; i++) begin
			filler_halfword(half);
			drive_write(a, half);
			a = a + 27'd2;
		end
	endtask

	// ========================================
	// Checks
	// ========================================

	task automatic report(input string name, input logic ok, input string expected,
			input string actual);
		test_count++;
		if (ok) begin
			$display("PASS %s", name);
		end else begin
			error_count++;
			$display("ERR %s expected %s actual %s", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		report(name, actual === expected, $sformatf("%b", expected), $sformatf("%b", actual));
	endtask

	task automatic check_bios(input string name, input bios_write_t expected,
			input bios_write_t actual);
		report(name, actual === expected, $sformatf("%h", expected), $sformatf("%h", actual));
	endtask

	task automatic check_cheat(input string name, input cheat_code_t expected,
			input cheat_code_t actual);
		report(name, actual === expected, $sformatf("%h", expected), $sformatf("%h", actual));
	endtask

	task automatic check_cart(input string name, input cart_info_t expected,
			input cart_info_t actual);
		report(name, actual === expected, $sformatf("%h", expected), $sformatf("%h", actual));
	endtask

	task automatic timed_out(input string name, input string pulse);
		test_count++;
		error_count++;
		$display("%s failed, %s never pulsed within %0d cycles", name, pulse, WAIT_LIMIT);
	endtask

	// 0 bios_wr, 1 cheat_clear, anything else cheat_valid
	function automatic logic strobe_now(input int which);
		case (which)
			0:       return bios_wr;
			1:       return cheat_clear;
			default: return cheat_valid;
		endcase
	endfunction

	task automatic wait_strobe(input int which, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
			step();
			seen = strobe_now(which);
		end
	endtask

	// ========================================
	// Vector interpreter
	// ========================================

	task automatic run_op(input string line);
		string       op;
		string       name;
		logic [31:0] val [5];
		int          fields;
		logic        seen;
		bios_write_t exp_bios;
		cheat_code_t exp_cheat;
		cart_info_t  exp_cart;

		fields = $sscanf(line, "%s", op);
		if (fields == 1 && op.getc(0) != "#") begin
			case (op)
				"S": begin
					fields = $sscanf(line, "%s %h", op, val[0]);
					start_download(val[0][7:0]);
				end
				"E": end_download();
				"H": begin
					fields        = $sscanf(line, "%s %h", op, val[0]);
					bios_homebrew = val[0][0];
				end
				"W": begin
					fields = $sscanf(line, "%s %h %h", op, val[0], val[1]);
					drive_write(val[0][26:0], val[1][15:0]);
				end
				"R": begin
					fields = $sscanf(line, "%s %h %h", op, val[0], val[1]);
					fill_writes(val[0][26:0], val[1]);
				end
				"B": begin
					fields        = $sscanf(line, "%s %s %h %h", op, name, val[0], val[1]);
					exp_bios.addr = val[0][11:0];
					exp_bios.data = val[1];
					wait_strobe(0, seen);
					if (seen)
						check_bios(name, exp_bios, bios_write);
					else
						timed_out(name, "bios_wr");
				end
				"Q": begin
					fields = $sscanf(line, "%s %s", op, name);
					wait_strobe(0, seen);
					test_count++;
					if (seen) begin
						error_count++;
						$display("%s failed, bios_wr pulsed while bios_homebrew was high", name);
					end else begin
						$display("PASS %s", name);
					end
				end
				"K": begin
					fields = $sscanf(line, "%s %s", op, name);
					wait_strobe(1, seen);
					if (seen)
						report(name, 1'b1, "", "");
					else
						timed_out(name, "cheat_clear");
				end
				"C": begin
					fields = $sscanf(line, "%s %s %h %h %h %h", op, name,
						val[0], val[1], val[2], val[3]);
					exp_cheat = {val[0], val[1], val[2], val[3]};
					wait_strobe(2, seen);
					if (seen)
						check_cheat(name, exp_cheat, cheat_code);
					else
						timed_out(name, "cheat_valid");
				end
				"I": begin
					fields = $sscanf(line, "%s %s %h %h %h %h %h", op, name,
						val[0], val[1], val[2], val[3], val[4]);
					exp_cart.loaded    = val[0][0];
					exp_cart.cart_type = val[1][1:0];
					exp_cart.flash_1m  = val[2][0];
					exp_cart.last_addr = val[3][26:0];
					exp_cart.quirks    = val[4][4:0];
					step(); // Cart levels settle two cycles after the bus
					step();
					check_cart(name, exp_cart, cart);
				end
				default: begin
					error_count++;
					$display("Unknown vector operation in line: %s", line);
				end
			endcase
		end
	endtask

	initial begin
		int    fd;
		int    got;
		string line;

		clk_sys       = 1'b0;
		reset         = 1'b1;
		ioctl         = '0;
		bios_homebrew = 1'b0;
		lfsr_state    = 32'h6cbb7e87;
		test_count    = 0;
		error_count   = 0;

		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		step();

		// Idle outputs before any download
		check_bit("reset_bios_wr", 1'b0, bios_wr);
		check_bit("reset_cheat_clear", 1'b0, cheat_clear);
		check_bit("reset_cheat_valid", 1'b0, cheat_valid);
		check_cart("reset_cart", '0, cart);

		fd = $fopen("dv/gba_loader_vectors.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Could not open the vector file dv/gba_loader_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got  = $fgets(line, fd);
				if (got > 0)
					run_op(line);
			end
			$fclose(fd);
		end

		$display("Tests run %0d, errors %0d", test_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* gba_loader.f */
rtl/gba_loader_pkg.sv
rtl/download_decode.sv
rtl/cart_header_scan.sv
rtl/bios_word_pack.sv
rtl/cheat_code_assemble.sv
rtl/gba_loader.sv
dv/gba_loader_tb.sv

/* Bender.yml */
package:
  name: gba_loader

sources:
  - rtl/gba_loader_pkg.sv
  - rtl/download_decode.sv
  - rtl/cart_header_scan.sv
  - rtl/bios_word_pack.sv
  - rtl/cheat_code_assemble.sv
  - rtl/gba_loader.sv
  - target: simulation
    files:
      - dv/gba_loader_tb.sv

/* dv/gba_loader_vectors.txt */
# Drive: S index | E | H level | W addr data | R addr count (random halfwords), all hex
# Check: B name addr data | Q name | K name | C name flags address compare replace | I name loaded type flash last_addr quirks
S 00
W 000100 1234
W 000102 ABCD
B bios_pair 040 ABCD1234
W 003FFC 5A5A
W 003FFE 0F0F
B bios_top FFF 0F0F5A5A
H 1
W 000200 1111
W 000202 2222
Q bios_homebrew
E
S FF
K cheat_clear
W 000000 0001
W 000002 0000
W 000004 1234
W 000006 0300
W 000008 00AA
W 00000A 0000
W 00000C 5678
W 00000E 9ABC
C cheat_code 00000001 03001234 000000AA 9ABC5678
E
S 41
R 000000 50
W 0000A0 4F42
W 0000A2 544B
W 0000A4 4941
W 0000A6 0000
W 0000A8 0000
W 0000AA 0000
R 0000AC 2A
W 000100 4C46
W 000102 5341
W 000104 3148
W 000106 5F4D
W 000108 8056
R 00010A 10
E
I cart_even_flash 1 1 1 000128 05
S 82
R 000000 50
W 0000A0 4F50
W 0000A2 454B
W 0000A4 4F4D
W 0000A6 204E
W 0000A8 4D45
W 0000AA 5245
R 0000AC 2A
W 000100 4600
W 000102 414C
W 000104 4853
W 000106 4D31
W 000108 565F
E
I cart_odd_flash 1 2 1 000108 04
S C3
R 000000 80
E
I cart_plain 1 3 0 0000FE 00
